// ==== rtl/conv2d_defines.svh ====
`ifndef CONV2D_DEFINES_SVH
`define CONV2D_DEFINES_SVH

// memory request widths
`define CONV2D_AWIDTH 32
`define CONV2D_DWIDTH 32

// kernel side, odd values only
`define CONV2D_WT_DIM 3

// fifo depths as log2
`define CONV2D_IN_LOGDEPTH 6
`define CONV2D_PE_LOGDEPTH 6
// output fifo holds a whole map, fm_dim up to 8
`define CONV2D_OUT_LOGDEPTH 6

`endif

// ==== rtl/conv2d_pkg.sv ====
`include "conv2d_defines.svh"

package conv2d_pkg;

    // one data word, wraps modulo 2^32
    typedef logic [`CONV2D_DWIDTH-1:0] word_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load_wt,
        st_load_fm,
        // walk finished, output still draining
        st_last_write,
        st_store_fm
    } ctrl_state_e;

endpackage

// ==== rtl/conv2d_fifo.sv ====
module conv2d_fifo import conv2d_pkg::*; #(
    parameter type T        = word_t,
    parameter int  LOGDEPTH = 6
) (
    input  logic clk,
    input  logic write_counter_rst,

    input  logic enq_valid,
    input  T     enq_data,
    output logic enq_ready,

    output logic deq_valid,
    output T     deq_data,
    input  logic deq_ready
);
    localparam int DEPTH = 1 << LOGDEPTH;
    localparam logic [LOGDEPTH:0] FULL_COUNT = {1'b1, {LOGDEPTH{1'b0}}};

    T mem [DEPTH];

    logic [LOGDEPTH-1:0] wr_ptr;
    logic [LOGDEPTH-1:0] rd_ptr;
    logic [LOGDEPTH:0]   count;
    logic                push;
    logic                pop;

    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];
    // a pop frees the slot in the same cycle when full
    assign enq_ready = (count != FULL_COUNT) || deq_ready;

    assign push = enq_valid && enq_ready;
    assign pop  = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/conv2d_pe.sv ====
`include "conv2d_defines.svh"

module conv2d_pe import conv2d_pkg::*; #(
    parameter int ROW = 0
) (
    input  logic        clk,
    input  logic        write_counter_rst,
    input  logic [31:0] fm_dim,

    input  word_t       pe_weight,
    input  logic        pe_weight_valid,
    input  word_t       pe_pixel,
    input  logic        pe_pixel_valid,
    input  logic        frame_start,

    output word_t       pe_result,
    output logic        pe_result_valid
);
    localparam int WT_DIM = `CONV2D_WT_DIM;
    localparam logic [31:0] WT_FIRST = ROW * WT_DIM;
    localparam logic [31:0] WT_LAST  = ROW * WT_DIM + WT_DIM - 1;
    localparam logic [31:0] WT_MAX   = WT_DIM * WT_DIM - 1;
    localparam logic [31:0] HALO     = WT_DIM - 1;
    localparam logic [31:0] ROW_Y    = ROW;

    logic [31:0] wt_cnt;
    logic [31:0] x_pos;
    logic [31:0] y_pos;
    logic [31:0] x_edge;
    logic        in_window;

    word_t weights [WT_DIM];
    // previous pixels of the row, oldest first
    word_t taps    [WT_DIM-1];
    word_t window  [WT_DIM];
    word_t dot;

    assign x_edge    = fm_dim + HALO - 32'd1;
    assign in_window = (y_pos >= ROW_Y) && (y_pos < ROW_Y + fm_dim) && (x_pos >= HALO);

    always_comb begin
        for (int k = 0; k < WT_DIM - 1; k++) begin
            window[k] = taps[k];
        end
        window[WT_DIM-1] = pe_pixel;
        dot = '0;
        // oldest pixel meets the first weight of the row
        for (int k = 0; k < WT_DIM; k++) begin
            dot = dot + window[k] * weights[k];
        end
    end

    always_ff @(posedge clk) begin
        if (pe_weight_valid && (wt_cnt >= WT_FIRST) && (wt_cnt <= WT_LAST)) begin
            weights[wt_cnt - WT_FIRST] <= pe_weight;
        end
        if (pe_pixel_valid) begin
            for (int k = 0; k < WT_DIM - 1; k++) begin
                taps[k] <= window[k+1];
            end
            pe_result <= dot;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wt_cnt          <= '0;
            x_pos           <= '0;
            y_pos           <= '0;
            pe_result_valid <= 1'b0;
        end else begin
            pe_result_valid <= pe_pixel_valid && in_window;
            if (pe_weight_valid) begin
                wt_cnt <= (wt_cnt == WT_MAX) ? '0 : wt_cnt + 32'd1;
            end
            if (frame_start) begin
                x_pos <= '0;
                y_pos <= '0;
            end else if (pe_pixel_valid) begin
                if (x_pos == x_edge) begin
                    x_pos <= '0;
                    y_pos <= y_pos + 32'd1;
                end else begin
                    x_pos <= x_pos + 32'd1;
                end
            end
        end
    end

endmodule

// ==== rtl/conv2d_controller.sv ====
`include "conv2d_defines.svh"

module conv2d_controller import conv2d_pkg::*; (
    input  logic                      clk,
    input  logic                      write_counter_rst,

    input  logic                      start,
    output logic                      idle,

    input  logic [31:0]               fm_dim,
    input  logic [31:0]               wt_offset,
    input  logic [31:0]               ifm_offset,
    input  logic [31:0]               ofm_offset,

    output logic [`CONV2D_AWIDTH-1:0] req_read_addr,
    output logic                      req_read_addr_valid,
    input  logic                      req_read_addr_ready,
    output logic [31:0]               req_read_len,

    output logic [`CONV2D_AWIDTH-1:0] req_write_addr,
    output logic                      req_write_addr_valid,
    input  logic                      req_write_addr_ready,
    output logic [31:0]               req_write_len,

    input  word_t                     in_data,
    input  logic                      in_valid,
    output logic                      in_ready,

    output word_t                     pe_weight,
    output logic                      pe_weight_valid,
    output word_t                     pe_pixel,
    output logic                      pe_pixel_valid,
    output logic                      frame_start,

    input  logic                      map_done,
    input  logic                      out_empty
);
    localparam int WT_DIM = `CONV2D_WT_DIM;
    localparam logic [31:0] WT_MAX  = WT_DIM - 1;
    localparam logic [31:0] WT_LEN  = WT_DIM * WT_DIM;
    localparam logic [31:0] HALO    = WT_DIM - 1;
    localparam logic [31:0] HALF    = (WT_DIM - 1) / 2;

    ctrl_state_e state;
    ctrl_state_e state_next;

    logic [31:0] m_cnt;
    logic [31:0] n_cnt;
    logic [31:0] x_cnt;
    logic [31:0] y_cnt;
    logic [31:0] walk_edge;
    logic        halo;
    logic        in_fire;
    logic        step;
    logic        wt_done;
    logic        walk_done;
    logic        rd_issue;
    logic        wr_issue;
    logic        wr_sent;

    assign idle      = (state == st_idle);
    assign walk_edge = fm_dim + HALO - 32'd1;

    // zero border around the map
    assign halo = (x_cnt < HALF) || (y_cnt < HALF) ||
                  (x_cnt >= fm_dim + HALF) || (y_cnt >= fm_dim + HALF);

    assign in_ready = (state == st_load_wt) || ((state == st_load_fm) && !halo);
    assign in_fire  = in_valid && in_ready;
    assign step     = (state == st_load_fm) && (halo || in_fire);

    assign pe_weight       = in_data;
    assign pe_weight_valid = (state == st_load_wt) && in_fire;
    assign pe_pixel        = halo ? '0 : in_data;
    assign pe_pixel_valid  = step;

    assign wt_done     = pe_weight_valid && (m_cnt == WT_MAX) && (n_cnt == WT_MAX);
    assign walk_done   = step && (x_cnt == walk_edge) && (y_cnt == walk_edge);
    assign frame_start = wt_done;

    assign rd_issue = (idle && start) || wt_done;
    assign wr_issue = (state == st_last_write) && map_done;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) state_next = st_load_wt;
            end
            st_load_wt: begin
                if (wt_done) state_next = st_load_fm;
            end
            st_load_fm: begin
                if (walk_done) state_next = st_last_write;
            end
            st_last_write: begin
                if (map_done) state_next = st_store_fm;
            end
            st_store_fm: begin
                if (wr_sent && out_empty) state_next = st_idle;
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state                <= st_idle;
            m_cnt                <= '0;
            n_cnt                <= '0;
            x_cnt                <= '0;
            y_cnt                <= '0;
            req_read_addr_valid  <= 1'b0;
            req_write_addr_valid <= 1'b0;
            wr_sent              <= 1'b0;
        end else begin
            state <= state_next;
            if (pe_weight_valid) begin
                if (n_cnt == WT_MAX) begin
                    n_cnt <= '0;
                    m_cnt <= (m_cnt == WT_MAX) ? '0 : m_cnt + 32'd1;
                end else begin
                    n_cnt <= n_cnt + 32'd1;
                end
            end
            if (step) begin
                if (x_cnt == walk_edge) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == walk_edge) ? '0 : y_cnt + 32'd1;
                end else begin
                    x_cnt <= x_cnt + 32'd1;
                end
            end
            // request valids held until accepted
            if (rd_issue) begin
                req_read_addr_valid <= 1'b1;
            end else if (req_read_addr_valid && req_read_addr_ready) begin
                req_read_addr_valid <= 1'b0;
            end
            if (wr_issue) begin
                req_write_addr_valid <= 1'b1;
                wr_sent              <= 1'b0;
            end else if (req_write_addr_valid && req_write_addr_ready) begin
                req_write_addr_valid <= 1'b0;
                wr_sent              <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idle && start) begin
            req_read_addr <= wt_offset;
            req_read_len  <= WT_LEN;
        end else if (wt_done) begin
            req_read_addr <= ifm_offset;
            req_read_len  <= fm_dim * fm_dim;
        end
        if (wr_issue) begin
            req_write_addr <= ofm_offset;
            req_write_len  <= fm_dim * fm_dim;
        end
    end

endmodule

// ==== rtl/conv2d_accumulate.sv ====
`include "conv2d_defines.svh"

module conv2d_accumulate import conv2d_pkg::*; (
    input  logic        clk,
    input  logic        write_counter_rst,
    input  logic [31:0] fm_dim,

    input  logic        pe_fifo_valid [`CONV2D_WT_DIM],
    input  word_t       pe_fifo_data  [`CONV2D_WT_DIM],
    output logic        pe_fifo_ready [`CONV2D_WT_DIM],

    output word_t       sum_data,
    output logic        sum_valid,
    input  logic        sum_ready,

    output logic        map_done
);
    localparam int WT_DIM = `CONV2D_WT_DIM;

    logic [31:0] word_cnt;
    logic        all_valid;
    logic        fire;
    logic        last_word;

    always_comb begin
        all_valid = 1'b1;
        sum_data  = '0;
        for (int i = 0; i < WT_DIM; i++) begin
            all_valid = all_valid && pe_fifo_valid[i];
            sum_data  = sum_data + pe_fifo_data[i];
        end
    end

    // heads leave together
    always_comb begin
        for (int i = 0; i < WT_DIM; i++) begin
            pe_fifo_ready[i] = all_valid && sum_ready;
        end
    end

    assign sum_valid = all_valid;
    assign fire      = all_valid && sum_ready;
    assign last_word = (word_cnt + 32'd1 == fm_dim * fm_dim);

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            word_cnt <= '0;
            map_done <= 1'b0;
        end else begin
            map_done <= fire && last_word;
            if (fire) begin
                word_cnt <= last_word ? '0 : word_cnt + 32'd1;
            end
        end
    end

endmodule

// ==== rtl/conv2d_compute.sv ====
`include "conv2d_defines.svh"

module conv2d_compute import conv2d_pkg::*; (
    input  logic                      clk,
    input  logic                      write_counter_rst,

    input  logic                      start,
    output logic                      idle,

    input  logic [31:0]               fm_dim,
    input  logic [31:0]               wt_offset,
    input  logic [31:0]               ifm_offset,
    input  logic [31:0]               ofm_offset,

    output logic [`CONV2D_AWIDTH-1:0] req_read_addr,
    output logic                      req_read_addr_valid,
    input  logic                      req_read_addr_ready,
    output logic [31:0]               req_read_len,

    input  word_t                     rdata,
    input  logic                      rdata_valid,
    output logic                      rdata_ready,

    output logic [`CONV2D_AWIDTH-1:0] req_write_addr,
    output logic                      req_write_addr_valid,
    input  logic                      req_write_addr_ready,
    output logic [31:0]               req_write_len,

    output word_t                     req_write_data,
    output logic                      req_write_data_valid,
    input  logic                      req_write_data_ready
);
    localparam int WT_DIM = `CONV2D_WT_DIM;

    word_t in_data;
    logic  in_valid;
    logic  in_ready;

    word_t pe_weight;
    logic  pe_weight_valid;
    word_t pe_pixel;
    logic  pe_pixel_valid;
    logic  frame_start;

    word_t pe_result       [WT_DIM];
    logic  pe_result_valid [WT_DIM];
    word_t pe_fifo_data    [WT_DIM];
    logic  pe_fifo_valid   [WT_DIM];
    logic  pe_fifo_ready   [WT_DIM];

    word_t sum_data;
    logic  sum_valid;
    logic  sum_ready;
    logic  map_done;

    conv2d_fifo #(.T(word_t), .LOGDEPTH(`CONV2D_IN_LOGDEPTH)) i_in_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_valid         (rdata_valid),
        .enq_data          (rdata),
        .enq_ready         (rdata_ready),
        .deq_valid         (in_valid),
        .deq_data          (in_data),
        .deq_ready         (in_ready)
    );

    conv2d_controller i_controller (
        .clk                  (clk),
        .write_counter_rst    (write_counter_rst),
        .start                (start),
        .idle                 (idle),
        .fm_dim               (fm_dim),
        .wt_offset            (wt_offset),
        .ifm_offset           (ifm_offset),
        .ofm_offset           (ofm_offset),
        .req_read_addr        (req_read_addr),
        .req_read_addr_valid  (req_read_addr_valid),
        .req_read_addr_ready  (req_read_addr_ready),
        .req_read_len         (req_read_len),
        .req_write_addr       (req_write_addr),
        .req_write_addr_valid (req_write_addr_valid),
        .req_write_addr_ready (req_write_addr_ready),
        .req_write_len        (req_write_len),
        .in_data              (in_data),
        .in_valid             (in_valid),
        .in_ready             (in_ready),
        .pe_weight            (pe_weight),
        .pe_weight_valid      (pe_weight_valid),
        .pe_pixel             (pe_pixel),
        .pe_pixel_valid       (pe_pixel_valid),
        .frame_start          (frame_start),
        .map_done             (map_done),
        .out_empty            (!req_write_data_valid)
    );

    // one pe and one fifo per kernel row
    for (genvar i = 0; i < WT_DIM; i++) begin : g_row
        conv2d_pe #(.ROW(i)) i_pe (
            .clk               (clk),
            .write_counter_rst (write_counter_rst),
            .fm_dim            (fm_dim),
            .pe_weight         (pe_weight),
            .pe_weight_valid   (pe_weight_valid),
            .pe_pixel          (pe_pixel),
            .pe_pixel_valid    (pe_pixel_valid),
            .frame_start       (frame_start),
            .pe_result         (pe_result[i]),
            .pe_result_valid   (pe_result_valid[i])
        );

        conv2d_fifo #(.T(word_t), .LOGDEPTH(`CONV2D_PE_LOGDEPTH)) i_pe_fifo (
            .clk               (clk),
            .write_counter_rst (write_counter_rst),
            .enq_valid         (pe_result_valid[i]),
            .enq_data          (pe_result[i]),
            .enq_ready         (),
            .deq_valid         (pe_fifo_valid[i]),
            .deq_data          (pe_fifo_data[i]),
            .deq_ready         (pe_fifo_ready[i])
        );
    end

    conv2d_accumulate i_accumulate (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .fm_dim            (fm_dim),
        .pe_fifo_valid     (pe_fifo_valid),
        .pe_fifo_data      (pe_fifo_data),
        .pe_fifo_ready     (pe_fifo_ready),
        .sum_data          (sum_data),
        .sum_valid         (sum_valid),
        .sum_ready         (sum_ready),
        .map_done          (map_done)
    );

    conv2d_fifo #(.T(word_t), .LOGDEPTH(`CONV2D_OUT_LOGDEPTH)) i_out_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_valid         (sum_valid),
        .enq_data          (sum_data),
        .enq_ready         (sum_ready),
        .deq_valid         (req_write_data_valid),
        .deq_data          (req_write_data),
        .deq_ready         (req_write_data_ready)
    );

endmodule

// ==== bench/conv2d_checker.sv ====
`include "conv2d_defines.svh"

module conv2d_checker import conv2d_pkg::*; (
    input  logic        clk,
    input  logic        write_counter_rst,
    input  logic        start,
    input  logic        idle,
    input  logic [31:0] fm_dim,
    input  logic [31:0] wt_offset,
    input  logic [31:0] ifm_offset,
    input  logic [31:0] ofm_offset,
    input  logic [31:0] req_read_addr,
    input  logic        req_read_addr_valid,
    input  logic        req_read_addr_ready,
    input  logic [31:0] req_read_len,
    input  word_t       rdata,
    input  logic        rdata_valid,
    input  logic        rdata_ready,
    input  logic [31:0] req_write_addr,
    input  logic        req_write_addr_valid,
    input  logic        req_write_addr_ready,
    input  logic [31:0] req_write_len,
    input  word_t       req_write_data,
    input  logic        req_write_data_valid,
    input  logic        req_write_data_ready,
    output int          check_errors,
    output int          words_checked
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WT_DIM = `CONV2D_WT_DIM;
    localparam int WT_LEN = WT_DIM * WT_DIM;
    localparam int HALF   = (WT_DIM - 1) / 2;
    localparam int MAX_PX = 64;

    word_t       wt_q [WT_LEN];
    word_t       px_q [MAX_PX];
    int          err_cnt    = 0;
    int          word_cnt   = 0;
    int          run_idx    = 0;
    int          run_dim    = 0;
    int          rd_req_cnt = 0;
    int          wr_req_cnt = 0;
    int          rd_words   = 0;
    int          wr_words   = 0;
    logic        run_active = 1'b0;
    logic        rst_seen   = 1'b0;
    logic        start_seen = 1'b0;
    logic        idle_q     = 1'b1;
    logic        rv_q;
    logic        rr_q;
    logic        wv_q;
    logic        wr_q;
    logic        dv_q;
    logic        dr_q;
    logic [63:0] rp_q;
    logic [63:0] wp_q;
    logic [63:0] dp_q;

    assign check_errors  = err_cnt;
    assign words_checked = word_cnt;

    // same-size correlation over a zero border, wraps modulo 2^32
    function automatic word_t ref_word(input int dim, input int oy, input int ox);
        word_t acc;
        int    iy;
        int    ix;
        acc = '0;
        for (int r = 0; r < WT_DIM; r++) begin
            for (int k = 0; k < WT_DIM; k++) begin
                iy = oy + r - HALF;
                ix = ox + k - HALF;
                if (iy >= 0 && iy < dim && ix >= 0 && ix < dim) begin
                    acc = acc + wt_q[r*WT_DIM+k] * px_q[iy*dim+ix];
                end
            end
        end
        return acc;
    endfunction

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("CHECK FAILED %s (run %0d): expected %0h, actual %0h",
                     what, run_idx, exp, act);
        end
    endtask

    task automatic fault(input string what);
        err_cnt++;
        $display("run %0d: %s", run_idx, what);
    endtask

    task automatic check_held(input string chan, input logic pv, input logic pr,
                              input logic [63:0] pd, input logic v, input logic [63:0] d);
        if (pv && !pr && (!v || d !== pd)) begin
            fault($sformatf("%s valid dropped or payload changed before transfer", chan));
        end
    endtask

    always @(posedge clk) begin
        if (write_counter_rst) begin
            rst_seen   <= 1'b1;
            run_active <= 1'b0;
            start_seen <= 1'b0;
            idle_q     <= 1'b1;
            rv_q       <= 1'b0;
            wv_q       <= 1'b0;
            dv_q       <= 1'b0;
        end else begin
            rst_seen <= 1'b0;
            if (rst_seen) begin
                compare("idle after reset", 1, idle);
                compare("valids after reset", 0,
                        {req_read_addr_valid, req_write_addr_valid, req_write_data_valid});
            end
            start_seen <= idle && start;
            if (start_seen) begin
                compare("idle after start", 0, idle);
            end
            if (idle && start) begin
                run_idx    <= run_idx + 1;
                run_dim    <= fm_dim;
                run_active <= 1'b1;
                rd_req_cnt <= 0;
                wr_req_cnt <= 0;
                rd_words   <= 0;
                wr_words   <= 0;
            end
            if (req_read_addr_valid && req_read_addr_ready) begin
                if (rd_req_cnt == 0) begin
                    compare("weight read address", wt_offset, req_read_addr);
                    compare("weight read length", WT_LEN, req_read_len);
                end else if (rd_req_cnt == 1) begin
                    compare("pixel read address", ifm_offset, req_read_addr);
                    compare("pixel read length", run_dim * run_dim, req_read_len);
                end else begin
                    fault("more than two read requests in one run");
                end
                rd_req_cnt <= rd_req_cnt + 1;
            end
            if (rdata_valid && rdata_ready && run_active) begin
                if (rd_words < WT_LEN) begin
                    wt_q[rd_words] <= rdata;
                end else if (rd_words - WT_LEN < MAX_PX) begin
                    px_q[rd_words-WT_LEN] <= rdata;
                end
                rd_words <= rd_words + 1;
            end
            if (req_write_addr_valid && req_write_addr_ready) begin
                if (wr_req_cnt == 0) begin
                    compare("write address", ofm_offset, req_write_addr);
                    compare("write length", run_dim * run_dim, req_write_len);
                end else begin
                    fault("more than one write request in one run");
                end
                wr_req_cnt <= wr_req_cnt + 1;
            end
            if (req_write_data_valid && req_write_data_ready) begin
                if (wr_words < run_dim * run_dim) begin
                    compare($sformatf("result[%0d]", wr_words),
                            ref_word(run_dim, wr_words / run_dim, wr_words % run_dim),
                            req_write_data);
                end else begin
                    fault("output word written beyond the end of the map");
                end
                wr_words <= wr_words + 1;
                word_cnt <= word_cnt + 1;
            end
            // idle rising closes the run
            if (idle && !idle_q && run_active) begin
                compare("read requests", 2, rd_req_cnt);
                compare("write requests", 1, wr_req_cnt);
                compare("words written", run_dim * run_dim, wr_words);
                run_active <= 1'b0;
            end
            idle_q <= idle;
            check_held("read address", rv_q, rr_q, rp_q, req_read_addr_valid,
                       {req_read_addr, req_read_len});
            check_held("write address", wv_q, wr_q, wp_q, req_write_addr_valid,
                       {req_write_addr, req_write_len});
            check_held("write data", dv_q, dr_q, dp_q, req_write_data_valid,
                       {32'd0, req_write_data});
            rv_q <= req_read_addr_valid;
            rr_q <= req_read_addr_ready;
            rp_q <= {req_read_addr, req_read_len};
            wv_q <= req_write_addr_valid;
            wr_q <= req_write_addr_ready;
            wp_q <= {req_write_addr, req_write_len};
            dv_q <= req_write_data_valid;
            dr_q <= req_write_data_ready;
            dp_q <= {32'd0, req_write_data};
        end
    end

endmodule

// ==== bench/conv2d_tb.sv ====
`include "conv2d_defines.svh"

module conv2d_tb import conv2d_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS  = 256;
    localparam int WAIT_LIMIT = 5000;

    logic        clk                  = 1'b0;
    logic        write_counter_rst    = 1'b1;
    logic        start                = 1'b0;
    logic        idle;
    logic [31:0] fm_dim               = '0;
    logic [31:0] wt_offset            = '0;
    logic [31:0] ifm_offset           = '0;
    logic [31:0] ofm_offset           = '0;
    logic [31:0] req_read_addr;
    logic        req_read_addr_valid;
    logic        req_read_addr_ready  = 1'b0;
    logic [31:0] req_read_len;
    word_t       rdata                = '0;
    logic        rdata_valid          = 1'b0;
    logic        rdata_ready;
    logic [31:0] req_write_addr;
    logic        req_write_addr_valid;
    logic        req_write_addr_ready = 1'b0;
    logic [31:0] req_write_len;
    word_t       req_write_data;
    logic        req_write_data_valid;
    logic        req_write_data_ready = 1'b0;

    int          check_errors;
    int          words_checked;
    int          timeout_errors       = 0;

    word_t       mem [MEM_WORDS];
    logic [31:0] lfsr                 = 32'h7c69_72d7;
    logic        stall_en             = 1'b0;
    int unsigned rd_ptr               = 0;
    int unsigned rd_left              = 0;

    always #10 clk = ~clk;

    conv2d_compute i_dut (
        .clk                  (clk),
        .write_counter_rst    (write_counter_rst),
        .start                (start),
        .idle                 (idle),
        .fm_dim               (fm_dim),
        .wt_offset            (wt_offset),
        .ifm_offset           (ifm_offset),
        .ofm_offset           (ofm_offset),
        .req_read_addr        (req_read_addr),
        .req_read_addr_valid  (req_read_addr_valid),
        .req_read_addr_ready  (req_read_addr_ready),
        .req_read_len         (req_read_len),
        .rdata                (rdata),
        .rdata_valid          (rdata_valid),
        .rdata_ready          (rdata_ready),
        .req_write_addr       (req_write_addr),
        .req_write_addr_valid (req_write_addr_valid),
        .req_write_addr_ready (req_write_addr_ready),
        .req_write_len        (req_write_len),
        .req_write_data       (req_write_data),
        .req_write_data_valid (req_write_data_valid),
        .req_write_data_ready (req_write_data_ready)
    );

    conv2d_checker i_checker (.*);

    // fibonacci lfsr over x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // memory model serving one read burst at a time
    always @(posedge clk) begin
        logic [3:0] bits;
        if (write_counter_rst) begin
            rdata_valid          <= 1'b0;
            req_read_addr_ready  <= 1'b0;
            req_write_addr_ready <= 1'b0;
            req_write_data_ready <= 1'b0;
            rd_left = 0;
        end else begin
            bits = stall_en ? take_bits(4) : 4'b1111;
            if (rdata_valid && rdata_ready) begin
                rd_ptr  = rd_ptr + 1;
                rd_left = rd_left - 1;
            end
            // a raised rdata_valid waits for its transfer
            if (!rdata_valid || rdata_ready) begin
                rdata_valid <= (rd_left != 0) && bits[0];
                rdata       <= mem[rd_ptr % MEM_WORDS];
            end
            if (req_read_addr_valid && req_read_addr_ready) begin
                rd_ptr  = req_read_addr;
                rd_left = req_read_len;
            end
            req_read_addr_ready  <= (rd_left == 0) && bits[3];
            req_write_addr_ready <= bits[1];
            req_write_data_ready <= bits[2];
        end
    end

    task automatic end_test();
        $display("errors: %0d check, %0d timeout; words checked: %0d",
                 check_errors, timeout_errors, words_checked);
        if (check_errors + timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic wait_idle(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (idle !== level && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (idle !== level) begin
            $display("timeout after %0d cycles waiting for %s", cycles, what);
            timeout_errors++;
        end
    endtask

    task automatic run_conv(input int dim, input int wt, input int ifm, input int ofm);
        fm_dim     <= dim;
        wt_offset  <= wt;
        ifm_offset <= ifm;
        ofm_offset <= ofm;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_idle(1'b0, "idle to fall after start");
        if (timeout_errors == 0) begin
            wait_idle(1'b1, "idle to return at the end of the run");
        end
        @(posedge clk);
    endtask

    initial begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = take_bits(32);
        end
        repeat (3) @(posedge clk);
        write_counter_rst <= 1'b0;
        @(posedge clk);
        run_conv(4, 0, 16, 100);
        // memory side stalls from here on
        stall_en <= 1'b1;
        if (timeout_errors == 0) begin
            run_conv(4, 40, 60, 120);
        end
        if (timeout_errors == 0) begin
            run_conv(5, 80, 90, 140);
        end
        repeat (4) @(posedge clk);
        end_test();
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/conv2d_pkg.sv
rtl/conv2d_fifo.sv
rtl/conv2d_pe.sv
rtl/conv2d_controller.sv
rtl/conv2d_accumulate.sv
rtl/conv2d_compute.sv
bench/conv2d_checker.sv
bench/conv2d_tb.sv

// ==== Bender.yml ====
package:
  name: conv2d

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/conv2d_pkg.sv
      - rtl/conv2d_fifo.sv
      - rtl/conv2d_pe.sv
      - rtl/conv2d_controller.sv
      - rtl/conv2d_accumulate.sv
      - rtl/conv2d_compute.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/conv2d_checker.sv
      - bench/conv2d_tb.sv
